// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_dual_pipe
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_dual_pipe.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module tb_dual_pipe
    import dual_issue_pkg::*;
();

    localparam int NUM_DIRECTED   = 16;
    localparam int NUM_RANDOM     = 3000;
    localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 4 + 100;
    // Full queue drain plus pipeline and credit return latency
    localparam int DRAIN_CYCLES   = 2 * `QUEUE_DEPTH + 8;

    // Kept R-type functs and I-type opcodes
    localparam logic [5:0] R_FUNCT [11] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                            6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
    localparam logic [5:0] I_OPC [6] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    word_t                in_inst;
    logic [`CREDIT_W-1:0] credit_ret;
    logic                 ret0_valid;
    logic                 ret0_wen;
    reg_addr_t            ret0_dest;
    word_t                ret0_data;
    logic                 ret1_valid;
    logic                 ret1_wen;
    reg_addr_t            ret1_dest;
    word_t                ret1_data;

    logic [31:0] lfsr = 32'hdb10_d90f;
    word_t       arch_regs [`REG_COUNT];
    word_t       exp_q [$];
    string       test_name = "reset";
    int          credits = `QUEUE_DEPTH;
    int          credit_total = 0;
    int          sent_total = 0;
    int          retired_total = 0;
    int          dual_total = 0;
    int          errors = 0;
    int          cycle_count = 0;
    logic        started = 1'b0;

    dual_pipe_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .credit_ret (credit_ret),
        .ret0_valid (ret0_valid),
        .ret0_wen   (ret0_wen),
        .ret0_dest  (ret0_dest),
        .ret0_data  (ret0_data),
        .ret1_valid (ret1_valid),
        .ret1_wen   (ret1_wen),
        .ret1_dest  (ret1_dest),
        .ret1_data  (ret1_data)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // Registers limited to r0..r7 so that dependences are frequent
    task automatic gen_inst(output word_t inst);
        logic [31:0] sel;
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] rd;
        logic [31:0] imm;
        logic [31:0] sh;
        int          idx;
        draw_bits(4, sel);
        draw_bits(3, rs);
        draw_bits(3, rt);
        draw_bits(3, rd);
        draw_bits(16, imm);
        draw_bits(5, sh);
        if (sel[3:0] == 4'h0) begin
            // Multiply/divide functs or load opcodes
            draw_bits(4, sel);
            if (sel[3]) begin
                inst = {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], 3'b011, sel[2:0]};
            end else begin
                inst = {3'b100, sel[2:0], rs[4:0], rt[4:0], imm[15:0]};
            end
        end else begin
            draw_bits(5, sel);
            idx = int'(sel % 32'd17);
            if (idx < 11) begin
                inst = {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], R_FUNCT[idx]};
            end else begin
                inst = {I_OPC[idx - 11], rs[4:0], rt[4:0], imm[15:0]};
            end
        end
    endtask

    function automatic logic reads_reg(word_t inst, reg_addr_t r);
        logic rd_rs;
        logic rd_rt;
        rd_rs = 1'b0;
        rd_rt = 1'b0;
        if (inst[31:26] == 6'h00) begin
            if (inst[5:0] inside {6'h00, 6'h02, 6'h03}) begin
                rd_rt = 1'b1;
            end else if (inst[5:0] inside {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                           6'h2a, 6'h2b}) begin
                rd_rs = 1'b1;
                rd_rt = 1'b1;
            end
        end else if (inst[31:26] inside {6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e}) begin
            rd_rs = 1'b1;
        end
        return (rd_rs && (inst[25:21] == r)) || (rd_rt && (inst[20:16] == r));
    endfunction

    // Architectural execution in program order
    task automatic model_exec(input word_t inst, output logic wen, output reg_addr_t dest,
                              output word_t data);
        word_t      a;
        word_t      b;
        word_t      sx;
        word_t      zx;
        logic [4:0] sh;
        a    = arch_regs[inst[25:21]];
        b    = arch_regs[inst[20:16]];
        sx   = {{16{inst[15]}}, inst[15:0]};
        zx   = {16'h0000, inst[15:0]};
        sh   = inst[10:6];
        wen  = 1'b1;
        data = '0;
        if (inst[31:26] == 6'h00) begin
            dest = inst[15:11];
            case (inst[5:0])
                6'h21:   data = a + b;
                6'h23:   data = a - b;
                6'h24:   data = a & b;
                6'h25:   data = a | b;
                6'h26:   data = a ^ b;
                6'h27:   data = ~(a | b);
                6'h2a:   data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h2b:   data = (a < b) ? 32'd1 : 32'd0;
                6'h00:   data = b << sh;
                6'h02:   data = b >> sh;
                6'h03:   data = $signed(b) >>> sh;
                default: wen = 1'b0;
            endcase
        end else begin
            dest = inst[20:16];
            case (inst[31:26])
                6'h09:   data = a + sx;
                6'h0a:   data = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                6'h0c:   data = a & zx;
                6'h0d:   data = a | zx;
                6'h0e:   data = a ^ zx;
                6'h0f:   data = {inst[15:0], 16'h0000};
                default: wen = 1'b0;
            endcase
        end
        if (wen && (dest != '0)) begin
            arch_regs[dest] = data;
        end
    endtask

    task automatic retire_lane(input string lane, input logic wen, input reg_addr_t dest,
                               input word_t data, output word_t inst,
                               output logic exp_wen, output reg_addr_t exp_dest);
        word_t exp_data;
        inst     = '0;
        exp_wen  = 1'b0;
        exp_dest = '0;
        if (exp_q.size() == 0) begin
            errors++;
            $display("%s retired an instruction that was never sent", lane);
        end else begin
            inst = exp_q.pop_front();
            model_exec(inst, exp_wen, exp_dest, exp_data);
            retired_total++;
            check_value({test_name, " ", lane, " wen"}, word_t'(exp_wen), word_t'(wen));
            // No-ops leave dest and data unspecified
            if (exp_wen) begin
                check_value({test_name, " ", lane, " dest"}, word_t'(exp_dest), word_t'(dest));
                check_value({test_name, " ", lane, " data"}, exp_data, data);
            end
        end
    endtask

    task automatic drive_cycle(input logic send, input word_t inst, output logic accepted);
        @(posedge clk);
        credits      += int'(credit_ret);
        credit_total += int'(credit_ret);
        if ((credits > `QUEUE_DEPTH) || (credits < 0)) begin
            errors++;
            $display("Source credit count %0d is out of range", credits);
        end
        accepted = send && (credits > 0);
        if (accepted) begin
            credits--;
            exp_q.push_back(inst);
            sent_total++;
            started = 1'b1;
        end
        in_valid <= accepted;
        in_inst  <= inst;
    endtask

    task automatic drain();
        logic taken;
        int   n;
        n = 0;
        while (((exp_q.size() != 0) || (credits != `QUEUE_DEPTH)) &&
               (n < DRAIN_CYCLES)) begin
            drive_cycle(1'b0, '0, taken);
            n++;
        end
    endtask

    always @(negedge clk) begin
        word_t     inst0;
        word_t     inst1;
        logic      wen0;
        logic      wen1;
        reg_addr_t dest0;
        reg_addr_t dest1;
        if (!rst) begin
            if (!started) begin
                check_value({test_name, " credit_ret"}, '0, word_t'(credit_ret));
                check_value({test_name, " ret0_valid"}, '0, word_t'(ret0_valid));
                check_value({test_name, " ret1_valid"}, '0, word_t'(ret1_valid));
            end
            if (ret1_valid && !ret0_valid) begin
                errors++;
                $display("Lane 1 retired in a cycle where lane 0 did not");
            end
            if (ret0_valid) begin
                retire_lane("lane0", ret0_wen, ret0_dest, ret0_data, inst0, wen0, dest0);
                if (ret1_valid) begin
                    retire_lane("lane1", ret1_wen, ret1_dest, ret1_data, inst1, wen1, dest1);
                    dual_total++;
                    if (wen0 && (dest0 != '0) && reads_reg(inst1, dest0)) begin
                        errors++;
                        $display("Lane 1 instruction %h retired together with lane 0 %h %s",
                                 inst1, inst0, "although it reads the register lane 0 writes");
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     TIMEOUT_CYCLES, retired_total, sent_total);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        word_t       inst;
        logic [31:0] r;
        logic        taken;
        int          i;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_inst  = '0;
        for (int k = 0; k < `REG_COUNT; k++) begin
            arch_regs[k] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            drive_cycle(1'b0, '0, taken);
        end

        // Back-to-back ori into r1..r7 from r0 with no dependence between them
        test_name = "independent";
        i = 0;
        while (i < NUM_DIRECTED) begin
            draw_bits(16, r);
            inst = {6'h0d, 5'd0, 5'((i % 7) + 1), r[15:0]};
            drive_cycle(1'b1, inst, taken);
            if (taken) begin
                i++;
            end
        end
        drain();

        test_name = "random";
        i = 0;
        while (i < NUM_RANDOM) begin
            gen_inst(inst);
            draw_bits(2, r);
            drive_cycle(r[1:0] != 2'b00, inst, taken);
            if (taken) begin
                i++;
            end
        end
        drain();

        test_name = "final";
        check_value("final credits returned", word_t'(sent_total), word_t'(credit_total));
        check_value("final instructions retired", word_t'(sent_total), word_t'(retired_total));
        check_value("final credits held", word_t'(`QUEUE_DEPTH), word_t'(credits));

        $display("Summary: %0d errors, %0d sent, %0d retired, %0d dual retires",
                 errors, sent_total, retired_total, dual_total);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: include/dual_issue_cfg.svh
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// Data path and instruction word width
`define DATA_W 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// Instruction queue entries, also the credits held after reset
`define QUEUE_DEPTH 8

// Wide enough for 0 to QUEUE_DEPTH
`define CREDIT_W 4

`endif

// File: rtl/dual_issue_pkg.sv
`include "dual_issue_cfg.svh"

package dual_issue_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Executed operations, immediate forms kept apart
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADDIU,
        OP_SLTI,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        reg_addr_t rs;
        reg_addr_t rt;
        logic      uses_rs;
        logic      uses_rt;
        reg_addr_t dest;
        logic      wen;
        // Raw immediate field, extended at issue
        logic [15:0] imm;
        logic [4:0]  shamt;
        logic        imm_zero_ext;
    } decoded_t;

endpackage

// File: rtl/dual_pipe_top.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module dual_pipe_top
    import dual_issue_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  word_t                in_inst,
    output logic [`CREDIT_W-1:0] credit_ret,
    output logic                 ret0_valid,
    output logic                 ret0_wen,
    output reg_addr_t            ret0_dest,
    output word_t                ret0_data,
    output logic                 ret1_valid,
    output logic                 ret1_wen,
    output reg_addr_t            ret1_dest,
    output word_t                ret1_data
);

    logic [1:0]           pop_count;
    logic [`CREDIT_W-1:0] count;
    word_t                head0;
    word_t                head1;

    reg_addr_t rs0_addr;
    reg_addr_t rt0_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rt1_addr;
    word_t     rs0_data;
    word_t     rt0_data;
    word_t     rs1_data;
    word_t     rt1_data;

    logic      ex0_wen;
    reg_addr_t ex0_dest;
    word_t     ex0_data;
    logic      ex1_wen;
    reg_addr_t ex1_dest;
    word_t     ex1_data;

    exec_lane_if lane0 ();
    exec_lane_if lane1 ();

    inst_queue i_queue (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .pop_count  (pop_count),
        .head0      (head0),
        .head1      (head1),
        .count      (count),
        .credit_ret (credit_ret)
    );

    issue_ctrl i_issue (
        .count     (count),
        .head0     (head0),
        .head1     (head1),
        .rs0_addr  (rs0_addr),
        .rt0_addr  (rt0_addr),
        .rs1_addr  (rs1_addr),
        .rt1_addr  (rt1_addr),
        .rs0_data  (rs0_data),
        .rt0_data  (rt0_data),
        .rs1_data  (rs1_data),
        .rt1_data  (rt1_data),
        .pop_count (pop_count),
        .lane0     (lane0),
        .lane1     (lane1)
    );

    // WB forwarding taps the retire ports directly
    reg_file_bypass i_rf (
        .clk      (clk),
        .rst      (rst),
        .rs0_addr (rs0_addr),
        .rs0_data (rs0_data),
        .rt0_addr (rt0_addr),
        .rt0_data (rt0_data),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_data),
        .rt1_addr (rt1_addr),
        .rt1_data (rt1_data),
        .ex0_wen  (ex0_wen),
        .ex0_dest (ex0_dest),
        .ex0_data (ex0_data),
        .ex1_wen  (ex1_wen),
        .ex1_dest (ex1_dest),
        .ex1_data (ex1_data),
        .wb0_wen  (ret0_wen),
        .wb0_dest (ret0_dest),
        .wb0_data (ret0_data),
        .wb1_wen  (ret1_wen),
        .wb1_dest (ret1_dest),
        .wb1_data (ret1_data)
    );

    exec_alu i_alu0 (
        .clk       (clk),
        .rst       (rst),
        .lane      (lane0),
        .ex_wen    (ex0_wen),
        .ex_dest   (ex0_dest),
        .ex_data   (ex0_data),
        .ret_valid (ret0_valid),
        .ret_wen   (ret0_wen),
        .ret_dest  (ret0_dest),
        .ret_data  (ret0_data)
    );

    exec_alu i_alu1 (
        .clk       (clk),
        .rst       (rst),
        .lane      (lane1),
        .ex_wen    (ex1_wen),
        .ex_dest   (ex1_dest),
        .ex_data   (ex1_data),
        .ret_valid (ret1_valid),
        .ret_wen   (ret1_wen),
        .ret_dest  (ret1_dest),
        .ret_data  (ret1_data)
    );

endmodule

// File: rtl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu
    import dual_issue_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    exec_lane_if.exec lane,
    output logic      ex_wen,
    output reg_addr_t ex_dest,
    output word_t     ex_data,
    output logic      ret_valid,
    output logic      ret_wen,
    output reg_addr_t ret_dest,
    output word_t     ret_data
);

    logic    ex_valid;
    alu_op_e ex_op;
    word_t   ex_a;
    word_t   ex_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            ex_wen    <= 1'b0;
            ret_valid <= 1'b0;
            ret_wen   <= 1'b0;
        end else begin
            ex_valid  <= lane.valid;
            ex_wen    <= lane.wen;
            ret_valid <= ex_valid;
            ret_wen   <= ex_wen;
        end
    end

    always_ff @(posedge clk) begin
        ex_op    <= lane.op;
        ex_dest  <= lane.dest;
        ex_a     <= lane.src_a;
        ex_b     <= lane.src_b;
        ret_dest <= ex_dest;
        ret_data <= ex_data;
    end

    // Shift amount sits in src_a, shifted value in src_b
    always_comb begin
        case (ex_op)
            OP_ADDU, OP_ADDIU: ex_data = ex_a + ex_b;
            OP_SUBU:           ex_data = ex_a - ex_b;
            OP_AND, OP_ANDI:   ex_data = ex_a & ex_b;
            OP_OR, OP_ORI:     ex_data = ex_a | ex_b;
            OP_XOR, OP_XORI:   ex_data = ex_a ^ ex_b;
            OP_NOR:            ex_data = ~(ex_a | ex_b);
            OP_SLT, OP_SLTI:   ex_data = word_t'($signed(ex_a) < $signed(ex_b));
            OP_SLTU:           ex_data = word_t'(ex_a < ex_b);
            OP_SLL:            ex_data = ex_b << ex_a[4:0];
            OP_SRL:            ex_data = ex_b >> ex_a[4:0];
            OP_SRA:            ex_data = word_t'($signed(ex_b) >>> ex_a[4:0]);
            OP_LUI:            ex_data = {ex_b[15:0], 16'h0000};
            default:           ex_data = '0;
        endcase
    end

    // Issue only raises wen on an issued lane
    a_wen_needs_valid: assert property (
        @(posedge clk) disable iff (rst)
        ret_wen |-> ret_valid
    );

endmodule

// File: rtl/exec_lane_if.sv
`timescale 1ns/1ps

// One lane's operation from issue into EX
interface exec_lane_if
    import dual_issue_pkg::*;
();

    logic      valid;
    alu_op_e   op;
    logic      wen;
    reg_addr_t dest;
    word_t     src_a;
    word_t     src_b;

    modport issue (
        output valid, op, wen, dest, src_a, src_b
    );

    modport exec (
        input valid, op, wen, dest, src_a, src_b
    );

endinterface

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import dual_issue_pkg::*;
(
    input  word_t    inst,
    output decoded_t dec
);

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       is_shift;

    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign is_shift = (funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA);

    always_comb begin
        dec       = '0;
        dec.op    = OP_NOP;
        dec.rs    = inst[25:21];
        dec.rt    = inst[20:16];
        dec.imm   = inst[15:0];
        dec.shamt = inst[10:6];
        if (opcode == OPC_SPECIAL) begin
            case (funct)
                FN_ADDU: dec.op = OP_ADDU;
                FN_SUBU: dec.op = OP_SUBU;
                FN_AND:  dec.op = OP_AND;
                FN_OR:   dec.op = OP_OR;
                FN_XOR:  dec.op = OP_XOR;
                FN_NOR:  dec.op = OP_NOR;
                FN_SLT:  dec.op = OP_SLT;
                FN_SLTU: dec.op = OP_SLTU;
                FN_SLL:  dec.op = OP_SLL;
                FN_SRL:  dec.op = OP_SRL;
                FN_SRA:  dec.op = OP_SRA;
                default: dec.op = OP_NOP;
            endcase
            dec.dest    = inst[15:11];
            dec.wen     = (dec.op != OP_NOP);
            dec.uses_rt = dec.wen;
            // Shifts take shamt instead of rs
            dec.uses_rs = dec.wen && !is_shift;
        end else begin
            case (opcode)
                OPC_ADDIU: dec.op = OP_ADDIU;
                OPC_SLTI:  dec.op = OP_SLTI;
                OPC_ANDI:  dec.op = OP_ANDI;
                OPC_ORI:   dec.op = OP_ORI;
                OPC_XORI:  dec.op = OP_XORI;
                OPC_LUI:   dec.op = OP_LUI;
                default:   dec.op = OP_NOP;
            endcase
            dec.dest         = inst[20:16];
            dec.wen          = (dec.op != OP_NOP);
            dec.uses_rs      = dec.wen && (dec.op != OP_LUI);
            dec.imm_zero_ext = (dec.op == OP_ANDI) || (dec.op == OP_ORI) ||
                               (dec.op == OP_XORI);
        end
    end

endmodule

// File: rtl/inst_queue.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module inst_queue
    import dual_issue_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  word_t                in_inst,
    input  logic [1:0]           pop_count,
    output word_t                head0,
    output word_t                head1,
    output logic [`CREDIT_W-1:0] count,
    output logic [`CREDIT_W-1:0] credit_ret
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    word_t mem [`QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_plus1;

    assign rd_ptr_plus1 = rd_ptr + PTR_W'(1);

    // Two oldest entries, head1 only meaningful when count >= 2
    assign head0 = mem[rd_ptr];
    assign head1 = mem[rd_ptr_plus1];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            rd_ptr     <= rd_ptr + PTR_W'(pop_count);
            count      <= count + `CREDIT_W'(in_valid) - `CREDIT_W'(pop_count);
            // Freed entries go back to the source one cycle later
            credit_ret <= `CREDIT_W'(pop_count);
        end
    end

    // Source must respect its credits
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> (count < `CREDIT_W'(`QUEUE_DEPTH))
    );

    // Issue never takes more than what is held
    a_no_pop_underflow: assert property (
        @(posedge clk) disable iff (rst)
        `CREDIT_W'(pop_count) <= count
    );

endmodule

// File: rtl/issue_ctrl.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module issue_ctrl
    import dual_issue_pkg::*;
(
    input  logic [`CREDIT_W-1:0] count,
    input  word_t                head0,
    input  word_t                head1,
    output reg_addr_t            rs0_addr,
    output reg_addr_t            rt0_addr,
    output reg_addr_t            rs1_addr,
    output reg_addr_t            rt1_addr,
    input  word_t                rs0_data,
    input  word_t                rt0_data,
    input  word_t                rs1_data,
    input  word_t                rt1_data,
    output logic [1:0]           pop_count,
    exec_lane_if.issue           lane0,
    exec_lane_if.issue           lane1
);

    decoded_t dec0;
    decoded_t dec1;
    logic     raw_hazard;
    logic     issue0;
    logic     issue1;

    function automatic word_t build_src_a(decoded_t d, word_t rs_data);
        return d.uses_rs ? rs_data : word_t'(d.shamt);
    endfunction

    function automatic word_t build_src_b(decoded_t d, word_t rt_data);
        word_t imm_ext;
        imm_ext = d.imm_zero_ext ? word_t'(d.imm) : word_t'($signed(d.imm));
        return d.uses_rt ? rt_data : imm_ext;
    endfunction

    inst_decoder i_dec0 (
        .inst (head0),
        .dec  (dec0)
    );

    inst_decoder i_dec1 (
        .inst (head1),
        .dec  (dec1)
    );

    assign rs0_addr = dec0.rs;
    assign rt0_addr = dec0.rt;
    assign rs1_addr = dec1.rs;
    assign rt1_addr = dec1.rt;

    // Younger reads what the older one writes, r0 excluded
    assign raw_hazard = dec0.wen && (dec0.dest != '0) &&
                        ((dec1.uses_rs && (dec1.rs == dec0.dest)) ||
                         (dec1.uses_rt && (dec1.rt == dec0.dest)));

    assign issue0    = (count != '0);
    assign issue1    = (count >= `CREDIT_W'(2)) && !raw_hazard;
    assign pop_count = {1'b0, issue0} + {1'b0, issue1};

    assign lane0.valid = issue0;
    assign lane0.op    = dec0.op;
    assign lane0.wen   = issue0 && dec0.wen;
    assign lane0.dest  = dec0.dest;
    assign lane0.src_a = build_src_a(dec0, rs0_data);
    assign lane0.src_b = build_src_b(dec0, rt0_data);

    assign lane1.valid = issue1;
    assign lane1.op    = dec1.op;
    assign lane1.wen   = issue1 && dec1.wen;
    assign lane1.dest  = dec1.dest;
    assign lane1.src_a = build_src_a(dec1, rs1_data);
    assign lane1.src_b = build_src_b(dec1, rt1_data);

endmodule

// File: rtl/reg_file_bypass.sv
`timescale 1ns/1ps
`include "dual_issue_cfg.svh"

module reg_file_bypass
    import dual_issue_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs0_addr,
    output word_t     rs0_data,
    input  reg_addr_t rt0_addr,
    output word_t     rt0_data,
    input  reg_addr_t rs1_addr,
    output word_t     rs1_data,
    input  reg_addr_t rt1_addr,
    output word_t     rt1_data,
    input  logic      ex0_wen,
    input  reg_addr_t ex0_dest,
    input  word_t     ex0_data,
    input  logic      ex1_wen,
    input  reg_addr_t ex1_dest,
    input  word_t     ex1_data,
    input  logic      wb0_wen,
    input  reg_addr_t wb0_dest,
    input  word_t     wb0_data,
    input  logic      wb1_wen,
    input  reg_addr_t wb1_dest,
    input  word_t     wb1_data
);

    word_t regs [`REG_COUNT];

    // Youngest producer first, lane 1 younger than lane 0
    function automatic word_t bypass_read(reg_addr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (ex1_wen && (ex1_dest == addr)) begin
            data = ex1_data;
        end else if (ex0_wen && (ex0_dest == addr)) begin
            data = ex0_data;
        end else if (wb1_wen && (wb1_dest == addr)) begin
            data = wb1_data;
        end else if (wb0_wen && (wb0_dest == addr)) begin
            data = wb0_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs0_data = bypass_read(rs0_addr);
        rt0_data = bypass_read(rt0_addr);
        rs1_data = bypass_read(rs1_addr);
        rt1_data = bypass_read(rt1_addr);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0_wen && (wb0_dest != '0)) begin
                regs[wb0_dest] <= wb0_data;
            end
            // Same destination, lane 1 overrides
            if (wb1_wen && (wb1_dest != '0)) begin
                regs[wb1_dest] <= wb1_data;
            end
        end
    end

    a_r0_stays_zero: assert property (
        @(posedge clk) disable iff (rst)
        ((wb0_wen && (wb0_dest == '0)) || (wb1_wen && (wb1_dest == '0)))
            |=> (regs[0] == '0)
    );

endmodule

// File: src.f
+incdir+include
rtl/dual_issue_pkg.sv
rtl/exec_lane_if.sv
rtl/inst_queue.sv
rtl/inst_decoder.sv
rtl/issue_ctrl.sv
rtl/reg_file_bypass.sv
rtl/exec_alu.sv
rtl/dual_pipe_top.sv
dv/tb_dual_pipe.sv
